// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status reflects the result
cd "$(dirname "$0")" && \
verilator --binary --timing -Wno-fatal -f tb.f \
    --top-module time_dmr_retry_tb -o time_dmr_retry_sim && \
./obj_dir/time_dmr_retry_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" && \
echo "run.sh: simulation passed" || \
{ echo "run.sh: simulation failed"; exit 1; }

// File: tb.f
verilog/dmr_pkg.sv
verilog/retry_start.sv
verilog/dmr_start.sv
verilog/opgroup_pipes.sv
verilog/rr_arb_lock.sv
verilog/dmr_end.sv
verilog/retry_end.sv
verilog/time_dmr_retry_top.sv
tests/time_dmr_retry_tb.sv

// File: tests/time_dmr_retry_tb.sv
`timescale 1ns/1ns

module time_dmr_retry_tb;
    import dmr_pkg::*;

    localparam int NUM_FIXED   = 10;
    localparam int NUM_BURST   = 20;
    localparam int NUM_ENTRIES = NUM_FIXED + NUM_BURST;
    localparam int MAX_CYCLES  = NUM_ENTRIES * 200;

    logic              clk_i;
    logic              reset_i;
    logic [DATA_W-1:0] data_i;
    op_e               op_i;
    logic              valid_i;
    logic              ready_o;
    logic              fault_arm_i;
    logic [ID_W-1:0]   fault_id_i;
    fault_kind_e       fault_kind_i;
    logic [DATA_W-1:0] fault_mask_i;
    logic [DATA_W-1:0] data_o;
    op_e               op_o;
    logic [ID_W-1:0]   id_o;
    logic              valid_o;
    logic              ready_i;
    logic              retry_o;

    // Stimulus table
    op_e               tbl_op    [NUM_ENTRIES];
    logic [DATA_W-1:0] tbl_data  [NUM_ENTRIES];
    logic              tbl_fault [NUM_ENTRIES];
    fault_kind_e       tbl_kind  [NUM_ENTRIES];
    logic [DATA_W-1:0] tbl_mask  [NUM_ENTRIES];
    logic              tbl_rdy   [NUM_ENTRIES];

    // Scoreboard of accepted items not yet delivered
    logic [ID_W-1:0]   exp_id   [$];
    op_e               exp_op   [$];
    logic [DATA_W-1:0] exp_data [$];
    logic [ID_W-1:0]   next_id;
    int                retry_count;
    int                expected_retries;
    logic              ready_random;

    time_dmr_retry_top time_dmr_retry_top_inst (
        .clk_i(clk_i), .reset_i(reset_i),
        .data_i(data_i), .op_i(op_i), .valid_i(valid_i), .ready_o(ready_o),
        .fault_arm_i(fault_arm_i), .fault_id_i(fault_id_i),
        .fault_kind_i(fault_kind_i), .fault_mask_i(fault_mask_i),
        .data_o(data_o), .op_o(op_o), .id_o(id_o), .valid_o(valid_o),
        .ready_i(ready_i), .retry_o(retry_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    task automatic set_entry(input int idx, input op_e op, input logic [DATA_W-1:0] data,
                             input logic fault, input fault_kind_e kind,
                             input logic [DATA_W-1:0] mask, input logic rdy);
        tbl_op[idx]    = op;
        tbl_data[idx]  = data;
        tbl_fault[idx] = fault;
        tbl_kind[idx]  = kind;
        tbl_mask[idx]  = mask;
        tbl_rdy[idx]   = rdy;
    endtask

    // Called at a falling edge and returns at the falling edge after acceptance
    task automatic send_item(input op_e op, input logic [DATA_W-1:0] data);
        valid_i = 1'b1;
        op_i    = op;
        data_i  = data;
        do @(posedge clk_i); while (!ready_o);
        exp_id.push_back(next_id);
        exp_op.push_back(op);
        exp_data.push_back(data);
        next_id = next_id + 1'b1;
        @(negedge clk_i);
        valid_i = 1'b0;
    endtask

    task automatic arm_fault(input logic [ID_W-1:0] id, input fault_kind_e kind,
                             input logic [DATA_W-1:0] mask);
        fault_arm_i  = 1'b1;
        fault_id_i   = id;
        fault_kind_i = kind;
        fault_mask_i = mask;
        @(negedge clk_i);
        fault_arm_i = 1'b0;
    endtask

    task automatic drain_outputs();
        while (exp_id.size() != 0) begin
            @(negedge clk_i);
        end
        check_value("retry_o count", retry_count, expected_retries);
    endtask

    // Same id may be reused while an older item is in flight, so match on content too
    task automatic match_output();
        int hit;
        int same_id;
        hit     = -1;
        same_id = -1;
        for (int i = 0; i < exp_id.size(); i++) begin
            if (exp_id[i] == id_o) begin
                if (same_id < 0) same_id = i;
                if (hit < 0 && exp_data[i] == data_o && exp_op[i] == op_o) hit = i;
            end
        end
        if (hit >= 0) begin
            exp_id.delete(hit);
            exp_op.delete(hit);
            exp_data.delete(hit);
        end else if (same_id >= 0) begin
            check_value("data_o", data_o, exp_data[same_id]);
            check_value("op_o", op_o, exp_op[same_id]);
        end else begin
            report_failure($sformatf("Output with id %h was not pending or came out twice",
                                     id_o));
        end
    endtask

    always @(posedge clk_i) begin
        if (!reset_i) begin
            if (valid_o && ready_i) match_output();
            if (retry_o) retry_count++;
        end
    end

    always @(negedge clk_i) begin
        if (ready_random) begin
            ready_i <= ($urandom % 2) != 0;
        end else begin
            ready_i <= 1'b1;
        end
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk_i);
        report_failure($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end

    initial begin
        void'($urandom(32'h8d142015));
        clk_i            = 1'b0;
        reset_i          = 1'b1;
        data_i           = '0;
        op_i             = OP_FAST;
        valid_i          = 1'b0;
        fault_arm_i      = 1'b0;
        fault_id_i       = '0;
        fault_kind_i     = FAULT_FLIP;
        fault_mask_i     = '0;
        ready_i          = 1'b1;
        ready_random     = 1'b0;
        next_id          = '0;
        retry_count      = 0;
        expected_retries = 0;

        set_entry(0, OP_FAST, 16'h1234, 1'b0, FAULT_FLIP, 16'h0000, 1'b0);
        set_entry(1, OP_MID,  16'hbeef, 1'b0, FAULT_FLIP, 16'h0000, 1'b0);
        set_entry(2, OP_SLOW, 16'h0f0f, 1'b0, FAULT_FLIP, 16'h0000, 1'b0);
        set_entry(3, OP_SLOW, 16'h5a5a, 1'b0, FAULT_FLIP, 16'h0000, 1'b0);
        set_entry(4, OP_FAST, 16'h0001, 1'b0, FAULT_FLIP, 16'h0000, 1'b0);
        set_entry(5, OP_MID,  16'hc3a5, 1'b1, FAULT_FLIP, 16'h00ff, 1'b0);
        // Dropped second copy leaves dmr_end in PAIR_HOLD until the timeout
        set_entry(6, OP_SLOW, 16'h7e57, 1'b1, FAULT_DROP, 16'h0000, 1'b0);
        set_entry(7, OP_FAST, 16'h0aa0, 1'b1, FAULT_FLIP, 16'h8000, 1'b0);
        set_entry(8, OP_FAST, 16'hd00d, 1'b1, FAULT_DROP, 16'h0000, 1'b0);
        set_entry(9, OP_MID,  16'h4242, 1'b0, FAULT_FLIP, 16'h0000, 1'b0);
        for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
            set_entry(i, op_e'($urandom % 3), DATA_W'($urandom), 1'b0, FAULT_FLIP,
                      16'h0000, 1'b1);
        end

        repeat (8) @(negedge clk_i);
        reset_i = 1'b0;

        // Idle outputs after reset
        repeat (4) begin
            @(negedge clk_i);
            check_value("valid_o", valid_o, 1'b0);
            check_value("retry_o", retry_o, 1'b0);
            check_value("ready_o", ready_o, 1'b1);
        end

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ready_random <= tbl_rdy[i];
            if (tbl_fault[i]) begin
                drain_outputs();
                arm_fault(next_id, tbl_kind[i], tbl_mask[i]);
                send_item(tbl_op[i], tbl_data[i]);
                expected_retries++;
                drain_outputs();
            end else begin
                send_item(tbl_op[i], tbl_data[i]);
            end
        end
        drain_outputs();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: verilog/dmr_end.sv
`timescale 1ns/1ns

module dmr_end (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [dmr_pkg::DATA_W-1:0] data_i,
    input  dmr_pkg::op_e               op_i,
    input  logic [dmr_pkg::ID_W-1:0]   id_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic [dmr_pkg::DATA_W-1:0] data_o,
    output dmr_pkg::op_e               op_o,
    output logic [dmr_pkg::ID_W-1:0]   id_o,
    output logic                       faulty_o,
    output logic                       valid_o,
    input  logic                       ready_i,
    output logic                       lock_o
);
    import dmr_pkg::*;

    pair_state_e             state_q;
    logic [DATA_W-1:0]       data_q;
    op_e                     op_q;
    logic [ID_W-1:0]         id_q;
    logic [LOCK_TIMER_W-1:0] timer_q;
    logic                    out_free;
    logic                    id_match;
    logic                    take_pair;
    logic                    timeout;

    assign out_free = !valid_o || ready_i;
    assign id_match = (id_i == id_q);
    assign lock_o   = (state_q == PAIR_HOLD);

    // A copy with another id means the partner is gone, so it waits for the timeout
    assign ready_o   = (state_q == PAIR_EMPTY) || (id_match && out_free);
    assign take_pair = (state_q == PAIR_HOLD) && valid_i && id_match && out_free;
    assign timeout   = (state_q == PAIR_HOLD) && !(valid_i && id_match) && out_free &&
                       (timer_q == LOCK_TIMER_W'(LOCK_TIMEOUT - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= PAIR_EMPTY;
            timer_q <= '0;
            valid_o <= 1'b0;
        end else begin
            case (state_q)
                PAIR_EMPTY: begin
                    if (valid_i) begin
                        state_q <= PAIR_HOLD;
                        timer_q <= '0;
                    end
                end
                PAIR_HOLD: begin
                    if (take_pair || timeout) begin
                        state_q <= PAIR_EMPTY;
                    end else if (out_free) begin
                        // Stalled output cycles do not count
                        timer_q <= timer_q + 1'b1;
                    end
                end
                default: state_q <= PAIR_EMPTY;
            endcase
            if (take_pair || timeout) begin
                valid_o <= 1'b1;
            end else if (ready_i) begin
                valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == PAIR_EMPTY && valid_i) begin
            data_q <= data_i;
            op_q   <= op_i;
            id_q   <= id_i;
        end
        if (take_pair || timeout) begin
            data_o   <= data_q;
            op_o     <= op_q;
            id_o     <= id_q;
            faulty_o <= timeout || (data_i != data_q);
        end
    end

endmodule

// File: verilog/dmr_pkg.sv
package dmr_pkg;

    // Payload and id widths
    localparam int DATA_W          = 16;
    localparam int ID_W            = 4;
    localparam int MAX_OUTSTANDING = 2 ** ID_W;

    // Operation groups and their register depths
    localparam int NUM_OPGROUPS     = 3;
    localparam int GRP_IDX_W        = $clog2(NUM_OPGROUPS);
    localparam int OPGROUP_STAGES_0 = 2;
    localparam int OPGROUP_STAGES_1 = 3;
    localparam int OPGROUP_STAGES_2 = 4;

    // Cycles to wait for the second copy
    localparam int LOCK_TIMEOUT = 5;
    localparam int LOCK_TIMER_W = $clog2(LOCK_TIMEOUT);

    // Operation selects the group, value 3 unused
    typedef enum logic [1:0] {
        OP_FAST = 2'd0,
        OP_MID  = 2'd1,
        OP_SLOW = 2'd2
    } op_e;

    typedef enum logic {
        FAULT_FLIP = 1'b0,
        FAULT_DROP = 1'b1
    } fault_kind_e;

    typedef enum logic {
        PAIR_EMPTY = 1'b0,
        PAIR_HOLD  = 1'b1
    } pair_state_e;

endpackage

// File: verilog/dmr_start.sv
`timescale 1ns/1ns

module dmr_start (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [dmr_pkg::DATA_W-1:0] data_i,
    input  dmr_pkg::op_e               op_i,
    input  logic [dmr_pkg::ID_W-1:0]   id_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic [dmr_pkg::DATA_W-1:0] data_o,
    output dmr_pkg::op_e               op_o,
    output logic [dmr_pkg::ID_W-1:0]   id_o,
    output logic                       copy_o,
    output logic                       valid_o,
    input  logic                       ready_i
);
    import dmr_pkg::*;

    logic              hold_q;
    logic [DATA_W-1:0] data_q;
    op_e               op_q;
    logic [ID_W-1:0]   id_q;

    // First copy passes straight through, second comes from the hold register
    assign valid_o = hold_q || valid_i;
    assign data_o  = hold_q ? data_q : data_i;
    assign op_o    = hold_q ? op_q : op_i;
    assign id_o    = hold_q ? id_q : id_i;
    assign copy_o  = hold_q;
    assign ready_o = !hold_q && ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hold_q <= 1'b0;
        end else if (valid_i && ready_o) begin
            hold_q <= 1'b1;
        end else if (ready_i) begin
            hold_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
            op_q   <= op_i;
            id_q   <= id_i;
        end
    end

endmodule

// File: verilog/opgroup_pipes.sv
`timescale 1ns/1ns

module op_delay_line #(
    parameter int NUM_REGS = 2
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [dmr_pkg::DATA_W-1:0] data_i,
    input  dmr_pkg::op_e               op_i,
    input  logic [dmr_pkg::ID_W-1:0]   id_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic [dmr_pkg::DATA_W-1:0] data_o,
    output dmr_pkg::op_e               op_o,
    output logic [dmr_pkg::ID_W-1:0]   id_o,
    output logic                       valid_o,
    input  logic                       ready_i
);
    import dmr_pkg::*;

    // Index s is the value after s register stages
    logic [DATA_W-1:0] pipe_data  [NUM_REGS+1];
    op_e               pipe_op    [NUM_REGS+1];
    logic [ID_W-1:0]   pipe_id    [NUM_REGS+1];
    logic              pipe_valid [NUM_REGS+1];
    logic              pipe_ready [NUM_REGS+1];

    assign pipe_data[0]         = data_i;
    assign pipe_op[0]           = op_i;
    assign pipe_id[0]           = id_i;
    assign pipe_valid[0]        = valid_i;
    assign ready_o              = pipe_ready[0];
    assign pipe_ready[NUM_REGS] = ready_i;

    for (genvar s = 0; s < NUM_REGS; s++) begin : gen_stage
        // Move on when the next stage drains or only holds a bubble
        assign pipe_ready[s] = pipe_ready[s+1] || !pipe_valid[s+1];

        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                pipe_valid[s+1] <= 1'b0;
            end else if (pipe_ready[s]) begin
                pipe_valid[s+1] <= pipe_valid[s];
            end
        end

        always_ff @(posedge clk_i) begin
            if (pipe_ready[s] && pipe_valid[s]) begin
                pipe_data[s+1] <= pipe_data[s];
                pipe_op[s+1]   <= pipe_op[s];
                pipe_id[s+1]   <= pipe_id[s];
            end
        end
    end

    assign data_o  = pipe_data[NUM_REGS];
    assign op_o    = pipe_op[NUM_REGS];
    assign id_o    = pipe_id[NUM_REGS];
    assign valid_o = pipe_valid[NUM_REGS];

endmodule

module opgroup_pipes (
    input  logic                                                  clk_i,
    input  logic                                                  reset_i,
    input  logic [dmr_pkg::DATA_W-1:0]                            data_i,
    input  dmr_pkg::op_e                                          op_i,
    input  logic [dmr_pkg::ID_W-1:0]                              id_i,
    input  logic                                                  copy_i,
    input  logic                                                  valid_i,
    output logic                                                  ready_o,
    input  logic                                                  fault_arm_i,
    input  logic [dmr_pkg::ID_W-1:0]                              fault_id_i,
    input  dmr_pkg::fault_kind_e                                  fault_kind_i,
    input  logic [dmr_pkg::DATA_W-1:0]                            fault_mask_i,
    output logic [dmr_pkg::NUM_OPGROUPS-1:0][dmr_pkg::DATA_W-1:0] grp_data_o,
    output dmr_pkg::op_e [dmr_pkg::NUM_OPGROUPS-1:0]              grp_op_o,
    output logic [dmr_pkg::NUM_OPGROUPS-1:0][dmr_pkg::ID_W-1:0]   grp_id_o,
    output logic [dmr_pkg::NUM_OPGROUPS-1:0]                      grp_valid_o,
    input  logic [dmr_pkg::NUM_OPGROUPS-1:0]                      grp_ready_i
);
    import dmr_pkg::*;

    logic                    armed_q;
    logic [ID_W-1:0]         fault_id_q;
    fault_kind_e             fault_kind_q;
    logic [DATA_W-1:0]       fault_mask_q;
    logic                    hit;
    logic                    drop;
    logic                    sel_ready;
    logic [DATA_W-1:0]       data_mod;
    logic [NUM_OPGROUPS-1:0] in_ready;

    // Only the second copy of the chosen id is hit
    assign hit      = armed_q && valid_i && copy_i && (id_i == fault_id_q);
    assign drop     = hit && (fault_kind_q == FAULT_DROP);
    assign data_mod = (hit && fault_kind_q == FAULT_FLIP) ? (data_i ^ fault_mask_q) : data_i;

    // Unused op code is swallowed
    always_comb begin
        sel_ready = 1'b1;
        for (int g = 0; g < NUM_OPGROUPS; g++) begin
            if (int'(op_i) == g) begin
                sel_ready = in_ready[g];
            end
        end
    end

    assign ready_o = drop || sel_ready;

    // One-shot, disarms once the copy is taken
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            armed_q <= 1'b0;
        end else if (fault_arm_i) begin
            armed_q <= 1'b1;
        end else if (hit && ready_o) begin
            armed_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fault_arm_i) begin
            fault_id_q   <= fault_id_i;
            fault_kind_q <= fault_kind_i;
            fault_mask_q <= fault_mask_i;
        end
    end

    for (genvar g = 0; g < NUM_OPGROUPS; g++) begin : gen_group
        op_delay_line #(
            .NUM_REGS(g == 0 ? OPGROUP_STAGES_0 : (g == 1 ? OPGROUP_STAGES_1 : OPGROUP_STAGES_2))
        ) i_delay_line (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .data_i  (data_mod),
            .op_i    (op_i),
            .id_i    (id_i),
            .valid_i (valid_i && !drop && (int'(op_i) == g)),
            .ready_o (in_ready[g]),
            .data_o  (grp_data_o[g]),
            .op_o    (grp_op_o[g]),
            .id_o    (grp_id_o[g]),
            .valid_o (grp_valid_o[g]),
            .ready_i (grp_ready_i[g])
        );
    end

endmodule

// File: verilog/retry_end.sv
`timescale 1ns/1ns

module retry_end (
    input  logic [dmr_pkg::DATA_W-1:0] data_i,
    input  dmr_pkg::op_e               op_i,
    input  logic [dmr_pkg::ID_W-1:0]   id_i,
    input  logic                       faulty_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic [dmr_pkg::DATA_W-1:0] data_o,
    output dmr_pkg::op_e               op_o,
    output logic [dmr_pkg::ID_W-1:0]   id_o,
    output logic                       valid_o,
    input  logic                       ready_i,
    output logic [dmr_pkg::ID_W-1:0]   failed_id_o,
    output logic                       failed_valid_o,
    input  logic                       failed_ready_i,
    output logic                       done_valid_o
);

    // Good results downstream
    assign data_o  = data_i;
    assign op_o    = op_i;
    assign id_o    = id_i;
    assign valid_o = valid_i && !faulty_i;

    // Faulty ids back to the front
    assign failed_id_o    = id_i;
    assign failed_valid_o = valid_i && faulty_i;

    assign ready_o      = faulty_i ? failed_ready_i : ready_i;
    assign done_valid_o = valid_o && ready_i;

endmodule

// File: verilog/retry_start.sv
`timescale 1ns/1ns

module retry_start (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [dmr_pkg::DATA_W-1:0] data_i,
    input  dmr_pkg::op_e               op_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic [dmr_pkg::DATA_W-1:0] data_o,
    output dmr_pkg::op_e               op_o,
    output logic [dmr_pkg::ID_W-1:0]   id_o,
    output logic                       valid_o,
    input  logic                       ready_i,
    input  logic [dmr_pkg::ID_W-1:0]   failed_id_i,
    input  logic                       failed_valid_i,
    output logic                       failed_ready_o,
    input  logic                       done_valid_i
);
    import dmr_pkg::*;

    logic [DATA_W-1:0] table_data [MAX_OUTSTANDING];
    op_e               table_op   [MAX_OUTSTANDING];
    logic [ID_W-1:0]   next_id_q;
    logic [ID_W:0]     outstanding_q;
    logic              out_free;
    logic              accept;
    logic              reissue;

    assign out_free       = !valid_o || ready_i;
    assign failed_ready_o = out_free;
    assign reissue        = failed_valid_i && out_free;

    // Retries block new items, as does a full id space
    assign ready_o = out_free && !failed_valid_i &&
                     (outstanding_q != (ID_W + 1)'(MAX_OUTSTANDING));
    assign accept  = valid_i && ready_o;

    // Stored copy per id for reissue
    always_ff @(posedge clk_i) begin
        if (accept) begin
            table_data[next_id_q] <= data_i;
            table_op[next_id_q]   <= op_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            next_id_q     <= '0;
            outstanding_q <= '0;
            valid_o       <= 1'b0;
        end else begin
            if (accept) begin
                next_id_q <= next_id_q + 1'b1;
            end
            outstanding_q <= outstanding_q + (ID_W + 1)'(accept) - (ID_W + 1)'(done_valid_i);
            if (reissue || accept) begin
                valid_o <= 1'b1;
            end else if (ready_i) begin
                valid_o <= 1'b0;
            end
        end
    end

    // Output register, failed id first
    always_ff @(posedge clk_i) begin
        if (reissue) begin
            data_o <= table_data[failed_id_i];
            op_o   <= table_op[failed_id_i];
            id_o   <= failed_id_i;
        end else if (accept) begin
            data_o <= data_i;
            op_o   <= op_i;
            id_o   <= next_id_q;
        end
    end

endmodule

// File: verilog/rr_arb_lock.sv
`timescale 1ns/1ns

module rr_arb_lock (
    input  logic                                                  clk_i,
    input  logic                                                  reset_i,
    input  logic [dmr_pkg::NUM_OPGROUPS-1:0]                      req_i,
    output logic [dmr_pkg::NUM_OPGROUPS-1:0]                      gnt_o,
    input  logic [dmr_pkg::NUM_OPGROUPS-1:0][dmr_pkg::DATA_W-1:0] data_i,
    input  dmr_pkg::op_e [dmr_pkg::NUM_OPGROUPS-1:0]              op_i,
    input  logic [dmr_pkg::NUM_OPGROUPS-1:0][dmr_pkg::ID_W-1:0]   id_i,
    input  logic                                                  lock_i,
    output logic                                                  req_o,
    input  logic                                                  gnt_i,
    output logic [dmr_pkg::DATA_W-1:0]                            data_o,
    output dmr_pkg::op_e                                          op_o,
    output logic [dmr_pkg::ID_W-1:0]                              id_o
);
    import dmr_pkg::*;

    logic [GRP_IDX_W-1:0] last_q;
    logic [GRP_IDX_W-1:0] idx;
    int                   cand;

    // Farthest candidate first, so the nearest one after the last winner overrides
    always_comb begin
        idx  = last_q;
        cand = 0;
        if (!lock_i) begin
            for (int i = NUM_OPGROUPS; i >= 1; i--) begin
                cand = (int'(last_q) + i) % NUM_OPGROUPS;
                if (req_i[cand]) begin
                    idx = GRP_IDX_W'(cand);
                end
            end
        end
    end

    assign req_o  = req_i[idx];
    assign gnt_o  = gnt_i ? (NUM_OPGROUPS'(1) << idx) : '0;
    assign data_o = data_i[idx];
    assign op_o   = op_i[idx];
    assign id_o   = id_i[idx];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            last_q <= GRP_IDX_W'(NUM_OPGROUPS - 1);
        end else if (req_o && gnt_i) begin
            last_q <= idx;
        end
    end

endmodule

// File: verilog/time_dmr_retry_top.sv
`timescale 1ns/1ns

module time_dmr_retry_top (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic [dmr_pkg::DATA_W-1:0] data_i,
    input  dmr_pkg::op_e               op_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    input  logic                       fault_arm_i,
    input  logic [dmr_pkg::ID_W-1:0]   fault_id_i,
    input  dmr_pkg::fault_kind_e       fault_kind_i,
    input  logic [dmr_pkg::DATA_W-1:0] fault_mask_i,
    output logic [dmr_pkg::DATA_W-1:0] data_o,
    output dmr_pkg::op_e               op_o,
    output logic [dmr_pkg::ID_W-1:0]   id_o,
    output logic                       valid_o,
    input  logic                       ready_i,
    output logic                       retry_o
);
    import dmr_pkg::*;

    // Retry start to DMR start
    logic [DATA_W-1:0] rs_data;
    op_e               rs_op;
    logic [ID_W-1:0]   rs_id;
    logic              rs_valid, rs_ready;

    // DMR start to the groups
    logic [DATA_W-1:0] ds_data;
    op_e               ds_op;
    logic [ID_W-1:0]   ds_id;
    logic              ds_copy, ds_valid, ds_ready;

    // Group outputs
    logic [NUM_OPGROUPS-1:0][DATA_W-1:0] grp_data;
    op_e [NUM_OPGROUPS-1:0]              grp_op;
    logic [NUM_OPGROUPS-1:0][ID_W-1:0]   grp_id;
    logic [NUM_OPGROUPS-1:0]             grp_valid, grp_ready;

    // Arbiter to DMR end, lock back
    logic [DATA_W-1:0] arb_data;
    op_e               arb_op;
    logic [ID_W-1:0]   arb_id;
    logic              arb_valid, arb_ready, lock;

    // DMR end to retry end
    logic [DATA_W-1:0] de_data;
    op_e               de_op;
    logic [ID_W-1:0]   de_id;
    logic              de_faulty, de_valid, de_ready;

    // Retry loop and completion
    logic [ID_W-1:0] failed_id;
    logic            failed_valid, failed_ready, done_valid;

    assign retry_o = failed_valid && failed_ready;

    retry_start i_retry_start (
        .clk_i(clk_i), .reset_i(reset_i),
        .data_i(data_i), .op_i(op_i), .valid_i(valid_i), .ready_o(ready_o),
        .data_o(rs_data), .op_o(rs_op), .id_o(rs_id), .valid_o(rs_valid), .ready_i(rs_ready),
        .failed_id_i(failed_id), .failed_valid_i(failed_valid),
        .failed_ready_o(failed_ready), .done_valid_i(done_valid)
    );

    dmr_start i_dmr_start (
        .clk_i(clk_i), .reset_i(reset_i),
        .data_i(rs_data), .op_i(rs_op), .id_i(rs_id), .valid_i(rs_valid), .ready_o(rs_ready),
        .data_o(ds_data), .op_o(ds_op), .id_o(ds_id), .copy_o(ds_copy),
        .valid_o(ds_valid), .ready_i(ds_ready)
    );

    opgroup_pipes i_opgroup_pipes (
        .clk_i(clk_i), .reset_i(reset_i),
        .data_i(ds_data), .op_i(ds_op), .id_i(ds_id), .copy_i(ds_copy),
        .valid_i(ds_valid), .ready_o(ds_ready),
        .fault_arm_i(fault_arm_i), .fault_id_i(fault_id_i),
        .fault_kind_i(fault_kind_i), .fault_mask_i(fault_mask_i),
        .grp_data_o(grp_data), .grp_op_o(grp_op), .grp_id_o(grp_id),
        .grp_valid_o(grp_valid), .grp_ready_i(grp_ready)
    );

    rr_arb_lock i_rr_arb_lock (
        .clk_i(clk_i), .reset_i(reset_i),
        .req_i(grp_valid), .gnt_o(grp_ready),
        .data_i(grp_data), .op_i(grp_op), .id_i(grp_id), .lock_i(lock),
        .req_o(arb_valid), .gnt_i(arb_ready),
        .data_o(arb_data), .op_o(arb_op), .id_o(arb_id)
    );

    dmr_end i_dmr_end (
        .clk_i(clk_i), .reset_i(reset_i),
        .data_i(arb_data), .op_i(arb_op), .id_i(arb_id), .valid_i(arb_valid), .ready_o(arb_ready),
        .data_o(de_data), .op_o(de_op), .id_o(de_id), .faulty_o(de_faulty),
        .valid_o(de_valid), .ready_i(de_ready), .lock_o(lock)
    );

    retry_end i_retry_end (
        .data_i(de_data), .op_i(de_op), .id_i(de_id), .faulty_i(de_faulty),
        .valid_i(de_valid), .ready_o(de_ready),
        .data_o(data_o), .op_o(op_o), .id_o(id_o), .valid_o(valid_o), .ready_i(ready_i),
        .failed_id_o(failed_id), .failed_valid_o(failed_valid),
        .failed_ready_i(failed_ready), .done_valid_o(done_valid)
    );

endmodule
